//--- hw/stm_pkg.sv
package stm_pkg;

  // widths shared by the timer, the tables and the host registers.
  localparam int sys_time_w = 64;
  localparam int freq_div_w = 32;
  localparam int cycle_w = 16;
  localparam int sample_w = 16;

  // one register stage per dividend bit.
  localparam int div_latency = sys_time_w;

  // host register map, selected by reg_addr.
  typedef enum logic [1:0] {
    reg_cycle,
    reg_freq_div,
    reg_segment,
    reg_commit
  } reg_addr_t;

  // the timer waits for a commit, then lets new settings flush through both dividers.
  typedef enum logic {
    st_wait,
    st_load
  } timer_state_t;

endpackage

//--- hw/pipe_divider.sv
`timescale 1ns/1ps

module pipe_divider #(
  parameter int dividend_w = 64,
  parameter int divisor_w = 32
) (
  input  logic                  CLK,
  input  logic [dividend_w-1:0] dividend,
  input  logic [divisor_w-1:0]  divisor,
  output logic [dividend_w-1:0] quotient,
  output logic [divisor_w-1:0]  remainder
);

  // each stage shifts one dividend bit into the partial remainder and keeps
  // the resolved quotient bit in the low end of its shift register.
  for (genvar k = 0; k < dividend_w; k++) begin : gen_stage
    logic [dividend_w-1:0] acc_in;
    logic [divisor_w-1:0]  rem_in;
    logic [divisor_w-1:0]  dsr_in;
    logic [divisor_w:0]    trial;
    logic [divisor_w:0]    diff;
    logic                  fits;
    logic [dividend_w-1:0] acc_q;
    logic [divisor_w-1:0]  rem_q;

    if (k == 0) begin : gen_first
      assign acc_in = dividend;
      assign rem_in = '0;
      assign dsr_in = divisor;
    end else begin : gen_next
      assign acc_in = gen_stage[k-1].acc_q;
      assign rem_in = gen_stage[k-1].rem_q;
      assign dsr_in = gen_stage[k-1].gen_carry.dsr_q;
    end

    assign trial = {rem_in, acc_in[dividend_w-1]};
    assign diff = trial - {1'b0, dsr_in};
    assign fits = trial >= {1'b0, dsr_in};

    always_ff @(posedge CLK) begin
      acc_q <= {acc_in[dividend_w-2:0], fits};
      // when the trial fails it is below the divisor, so it fits the narrower width.
      rem_q <= fits ? diff[divisor_w-1:0] : trial[divisor_w-1:0];
    end

    // the divisor travels with its operands so that a new one can enter every cycle.
    if (k < dividend_w - 1) begin : gen_carry
      logic [divisor_w-1:0] dsr_q;

      always_ff @(posedge CLK) begin
        dsr_q <= dsr_in;
      end
    end
  end

  assign quotient = gen_stage[dividend_w-1].acc_q;
  assign remainder = gen_stage[dividend_w-1].rem_q;

  a_divisor_nonzero: assert property (@(posedge CLK) divisor != '0)
    else $error("pipe_divider: zero divisor entered the pipeline");

endmodule

//--- hw/stm_settings.sv
`timescale 1ns/1ps

module stm_settings import stm_pkg::*; #(
  parameter int num_segment = 2,
  localparam int seg_w = (num_segment > 1) ? $clog2(num_segment) : 1
) (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  reg_we,
  input  reg_addr_t             reg_addr,
  input  logic [seg_w-1:0]      reg_seg,
  input  logic [31:0]           reg_data,
  input  logic                  update_done,
  output logic [cycle_w-1:0]    cycle [num_segment],
  output logic [freq_div_w-1:0] freq_div [num_segment],
  output logic [seg_w-1:0]      req_segment,
  output logic                  update_in,
  output logic                  busy
);

  logic commit;
  logic busy_q;
  logic seg_ok;

  assign commit = reg_we && (reg_addr == reg_commit);
  assign seg_ok = int'(reg_seg) < num_segment;

  // busy drops in the same cycle as update_done, so a commit there is taken.
  assign busy = busy_q && !update_done;

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < num_segment; i++) begin
        cycle[i] <= '0;
        freq_div[i] <= freq_div_w'(1);
      end
      req_segment <= '0;
    end else if (reg_we) begin
      case (reg_addr)
        reg_cycle: if (seg_ok) cycle[reg_seg] <= reg_data[cycle_w-1:0];
        reg_freq_div: if (seg_ok) freq_div[reg_seg] <= reg_data[freq_div_w-1:0];
        reg_segment: if (reg_data < num_segment) req_segment <= reg_data[seg_w-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      update_in <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      update_in <= commit && !busy;
      if (commit && !busy) begin
        busy_q <= 1'b1;
      end else if (update_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  a_freq_div_nonzero: assert property (@(posedge CLK) disable iff (reset)
    (reg_we && reg_addr == reg_freq_div) |-> reg_data[freq_div_w-1:0] != '0)
    else $error("stm_settings: freq_div written with zero");

endmodule

//--- hw/stm_timer.sv
`timescale 1ns/1ps

module stm_timer import stm_pkg::*; #(
  parameter int num_segment = 2
) (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  update_in,
  input  logic [sys_time_w-1:0] sys_time,
  input  logic [cycle_w-1:0]    cycle [num_segment],
  input  logic [freq_div_w-1:0] freq_div [num_segment],
  output logic [cycle_w-1:0]    idx [num_segment],
  output logic                  update_done
);

  localparam int period_w = cycle_w + 1;
  localparam int cnt_w = $clog2(2 * div_latency);

  timer_state_t state;
  logic [cnt_w-1:0] cnt;
  logic load;

  assign load = (state == st_wait) && update_in;

  for (genvar i = 0; i < num_segment; i++) begin : gen_seg
    logic [freq_div_w-1:0] freq_div_q = freq_div_w'(1);
    logic [period_w-1:0] period_q = period_w'(1);
    logic [sys_time_w-1:0] scaled;
    logic [period_w-1:0] phase;

    // the period is held as cycle plus one, which is never zero.
    always_ff @(posedge CLK) begin
      if (reset) begin
        freq_div_q <= freq_div_w'(1);
        period_q <= period_w'(1);
      end else if (load) begin
        freq_div_q <= freq_div[i];
        period_q <= {1'b0, cycle[i]} + period_w'(1);
      end
    end

    pipe_divider #(
      .dividend_w(sys_time_w),
      .divisor_w(freq_div_w)
    ) u_div_time (
      .CLK(CLK),
      .dividend(sys_time),
      .divisor(freq_div_q),
      .quotient(scaled),
      .remainder()
    );

    pipe_divider #(
      .dividend_w(sys_time_w),
      .divisor_w(period_w)
    ) u_div_period (
      .CLK(CLK),
      .dividend(scaled),
      .divisor(period_q),
      .quotient(),
      .remainder(phase)
    );

    assign idx[i] = phase[cycle_w-1:0];
  end

  // update_done rises 128 edges after the edge that took update_in, when the
  // last time sampled with the old settings has left the second divider.
  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= st_wait;
      cnt <= '0;
      update_done <= 1'b0;
    end else begin
      update_done <= 1'b0;
      case (state)
        st_wait: begin
          if (update_in) begin
            cnt <= '0;
            state <= st_load;
          end
        end
        st_load: begin
          cnt <= cnt + 1'b1;
          if (cnt == cnt_w'(2 * div_latency - 1)) begin
            update_done <= 1'b1;
            state <= st_wait;
          end
        end
        default: state <= st_wait;
      endcase
    end
  end

  a_no_commit_in_load: assert property (@(posedge CLK) disable iff (reset)
    update_in |-> state == st_wait)
    else $error("stm_timer: commit arrived while settings were loading");

endmodule

//--- hw/stm_sample_mem.sv
`timescale 1ns/1ps

module stm_sample_mem import stm_pkg::*; #(
  parameter int num_segment = 2,
  parameter int addr_w = 8,
  localparam int seg_w = (num_segment > 1) ? $clog2(num_segment) : 1
) (
  input  logic                CLK,
  input  logic                mem_we,
  input  logic [seg_w-1:0]    mem_seg,
  input  logic [addr_w-1:0]   mem_addr,
  input  logic [sample_w-1:0] mem_data,
  input  logic [cycle_w-1:0]  idx [num_segment],
  output logic [sample_w-1:0] rd_data [num_segment]
);

  localparam int depth = 2 ** addr_w;

  // one table per segment so that every segment is read in every cycle.
  for (genvar i = 0; i < num_segment; i++) begin : gen_table
    logic [sample_w-1:0] tbl [depth];
    logic [sample_w-1:0] rd_q;
    logic [addr_w-1:0] rd_addr;

    // the index wraps at the table depth when cycle is set beyond it.
    assign rd_addr = idx[i][addr_w-1:0];

    always_ff @(posedge CLK) begin
      if (mem_we && mem_seg == seg_w'(i)) begin
        tbl[mem_addr] <= mem_data;
      end
    end

    always_ff @(posedge CLK) begin
      rd_q <= tbl[rd_addr];
    end

    assign rd_data[i] = rd_q;
  end

  a_seg_in_range: assert property (@(posedge CLK)
    mem_we |-> int'(mem_seg) < num_segment)
    else $error("stm_sample_mem: write to a segment that does not exist");

endmodule

//--- hw/stm_output.sv
`timescale 1ns/1ps

module stm_output import stm_pkg::*; #(
  parameter int num_segment = 2,
  localparam int seg_w = (num_segment > 1) ? $clog2(num_segment) : 1
) (
  input  logic                CLK,
  input  logic                reset,
  input  logic [seg_w-1:0]    req_segment,
  input  logic                update_done,
  input  logic [sample_w-1:0] rd_data [num_segment],
  output logic [seg_w-1:0]    segment,
  output logic [sample_w-1:0] sample_out
);

  // the segment only changes once the timer reports clean indices for the new settings.
  always_ff @(posedge CLK) begin
    if (reset) begin
      segment <= '0;
    end else if (update_done) begin
      segment <= req_segment;
    end
  end

  // selection uses the registered segment, so the switch lands one edge after it.
  always_ff @(posedge CLK) begin
    if (reset) begin
      sample_out <= '0;
    end else begin
      sample_out <= rd_data[segment];
    end
  end

endmodule

//--- hw/stm_core.sv
`timescale 1ns/1ps

module stm_core import stm_pkg::*; #(
  parameter int num_segment = 2,
  parameter int addr_w = 8,
  localparam int seg_w = (num_segment > 1) ? $clog2(num_segment) : 1
) (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  reg_we,
  input  reg_addr_t             reg_addr,
  input  logic [seg_w-1:0]      reg_seg,
  input  logic [31:0]           reg_data,
  input  logic                  mem_we,
  input  logic [seg_w-1:0]      mem_seg,
  input  logic [addr_w-1:0]     mem_addr,
  input  logic [sample_w-1:0]   mem_data,
  input  logic [sys_time_w-1:0] sys_time,
  output logic                  busy,
  output logic                  update_done,
  output logic [seg_w-1:0]      segment,
  output logic [sample_w-1:0]   sample_out
);

  logic [cycle_w-1:0] cycle [num_segment];
  logic [freq_div_w-1:0] freq_div [num_segment];
  logic [seg_w-1:0] req_segment;
  logic update_in;
  logic [cycle_w-1:0] idx [num_segment];
  logic [sample_w-1:0] rd_data [num_segment];

  stm_settings #(.num_segment(num_segment)) u_settings (
    .CLK(CLK), .reset(reset), .reg_we(reg_we), .reg_addr(reg_addr), .reg_seg(reg_seg),
    .reg_data(reg_data), .update_done(update_done), .cycle(cycle), .freq_div(freq_div),
    .req_segment(req_segment), .update_in(update_in), .busy(busy)
  );

  stm_timer #(.num_segment(num_segment)) u_timer (
    .CLK(CLK), .reset(reset), .update_in(update_in), .sys_time(sys_time),
    .cycle(cycle), .freq_div(freq_div), .idx(idx), .update_done(update_done)
  );

  stm_sample_mem #(.num_segment(num_segment), .addr_w(addr_w)) u_sample_mem (
    .CLK(CLK), .mem_we(mem_we), .mem_seg(mem_seg), .mem_addr(mem_addr),
    .mem_data(mem_data), .idx(idx), .rd_data(rd_data)
  );

  stm_output #(.num_segment(num_segment)) u_output (
    .CLK(CLK), .reset(reset), .req_segment(req_segment), .update_done(update_done),
    .rd_data(rd_data), .segment(segment), .sample_out(sample_out)
  );

endmodule

//--- test/stm_core_tests.svh
task automatic reset_state();
  int err_before;
  err_before = errors;
  check_value("busy", 64'(busy), 64'd0);
  check_value("update_done", 64'(update_done), 64'd0);
  check_value("segment", 64'(segment), 64'd0);
  check_value("sample_out", 64'(sample_out), 64'd0);
  report_test("reset_state", err_before);
endtask

task automatic commit_timing();
  int err_before;
  int pulses;
  int first_pulse;
  err_before = errors;
  pulses = 0;
  first_pulse = 0;
  reg_we = 1'b1;
  reg_addr = reg_commit;
  reg_data = '0;
  advance();
  reg_we = 1'b0;
  for (int k = 1; k <= 2 * done_advance + 40; k++) begin
    if (update_done) begin
      pulses++;
      if (first_pulse == 0) first_pulse = k;
    end
    check_value("busy", 64'(busy), 64'(k < done_advance));
    // a second commit while busy must be dropped.
    reg_we = (k == 10);
    advance();
  end
  check_value("update_done pulse count", 64'(pulses), 64'd1);
  check_value("update_done delay", 64'(first_pulse), 64'(done_advance));
  report_test("commit_timing", err_before);
endtask

task automatic index_path();
  int err_before;
  int lat;
  err_before = errors;
  rand_time = 1'b0;
  load_table(0);
  write_reg(reg_freq_div, 0, 32'd3);
  write_reg(reg_cycle, 0, 32'd9);
  commit_and_wait(0, 0, 1'b0, lat);
  check_value("commit latency", 64'(lat), 64'(done_advance));
  repeat (300) begin
    advance();
    check_sample(0);
  end
  report_test("index_path", err_before);
endtask

task automatic segment_switch();
  int err_before;
  int lat;
  err_before = errors;
  load_table(1);
  write_reg(reg_freq_div, 1, 32'd5);
  write_reg(reg_cycle, 1, 32'd23);
  write_reg(reg_segment, 0, 32'd1);
  commit_and_wait(0, 1, 1'b1, lat);
  check_value("commit latency", 64'(lat), 64'(done_advance));
  repeat (200) begin
    advance();
    check_value("segment", 64'(segment), 64'd1);
    check_sample(1);
  end
  report_test("segment_switch", err_before);
endtask

task automatic random_settings();
  int err_before;
  int lat;
  int seg;
  int old_seg;
  logic [63:0] r;
  logic [63:0] sh;
  logic [31:0] fdiv;
  logic [31:0] cyc;
  err_before = errors;
  rand_time = 1'b1;
  old_seg = 1;
  for (int round = 0; round < 6; round++) begin
    r = rand_bits(1);
    seg = int'(r[0]);
    r = rand_bits(32);
    sh = rand_bits(5);
    // a random shift spreads the divider over small and large values.
    fdiv = r[31:0] >> sh[4:0];
    if (fdiv == 32'd0) fdiv = 32'd1;
    r = rand_bits(addr_w);
    cyc = 32'(r[addr_w-1:0]);
    write_reg(reg_freq_div, seg, fdiv);
    write_reg(reg_cycle, seg, cyc);
    write_reg(reg_segment, 0, 32'(seg));
    commit_and_wait(old_seg, seg, 1'b0, lat);
    repeat (150) begin
      advance();
      check_sample(seg);
    end
    old_seg = seg;
  end
  report_test("random_settings", err_before);
endtask

//--- test/stm_core_tb.sv
`timescale 1ns/1ps

module stm_core_tb import stm_pkg::*; ();

  localparam int num_segment = 2;
  localparam int addr_w = 8;
  localparam int depth = 2 ** addr_w;
  // sample_out after an edge comes from the time taken 129 edges before it.
  localparam int path_latency = 130;
  // commit edge, one edge to update_in, then 128 cycles in the timer.
  localparam int done_advance = 2 * div_latency + 2;
  localparam int hist_depth = 256;
  // the tests take about 3400 cycles, so this limit only trips on a hang.
  localparam int max_cycles = 20000;

  logic CLK;
  logic reset;
  logic reg_we;
  reg_addr_t reg_addr;
  logic [0:0] reg_seg;
  logic [31:0] reg_data;
  logic mem_we;
  logic [0:0] mem_seg;
  logic [addr_w-1:0] mem_addr;
  logic [sample_w-1:0] mem_data;
  logic [sys_time_w-1:0] sys_time;
  logic busy;
  logic update_done;
  logic [0:0] segment;
  logic [sample_w-1:0] sample_out;

  logic [31:0] lfsr_state = 32'hddf3;
  logic [sys_time_w-1:0] hist [hist_depth];
  logic [sample_w-1:0] tbl_copy [num_segment][depth];
  logic [cycle_w-1:0] exp_cycle [num_segment];
  logic [freq_div_w-1:0] exp_fdiv [num_segment];
  int cyc_count = 0;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  bit rand_time = 1'b0;

  stm_core #(.num_segment(num_segment), .addr_w(addr_w)) DUT (
    .CLK(CLK), .reset(reset), .reg_we(reg_we), .reg_addr(reg_addr), .reg_seg(reg_seg),
    .reg_data(reg_data), .mem_we(mem_we), .mem_seg(mem_seg), .mem_addr(mem_addr),
    .mem_data(mem_data), .sys_time(sys_time), .busy(busy), .update_done(update_done),
    .segment(segment), .sample_out(sample_out)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // the time history is indexed by the number of the edge that sampled it.
  always @(posedge CLK) begin
    cyc_count = cyc_count + 1;
    hist[cyc_count % hist_depth] = sys_time;
    if (cyc_count >= max_cycles) begin
      $display("timeout: the run reached %0d cycles before the tests finished", max_cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic [sample_w-1:0] expected_sample(input int seg, input logic [63:0] t);
    logic [63:0] scaled;
    logic [63:0] phase;
    scaled = t / {32'd0, exp_fdiv[seg]};
    phase = scaled % ({48'd0, exp_cycle[seg]} + 64'd1);
    return tbl_copy[seg][phase[addr_w-1:0]];
  endfunction

  task automatic advance();
    @(negedge CLK);
    if (rand_time) begin
      sys_time = rand_bits(64);
    end else begin
      sys_time = sys_time + 64'd1;
    end
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp)
      else begin
        $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        errors++;
      end
  endtask

  task automatic check_sample(input int seg);
    logic [sys_time_w-1:0] t;
    logic [sample_w-1:0] exp;
    t = hist[(cyc_count - (path_latency - 1)) % hist_depth];
    exp = expected_sample(seg, t);
    checks++;
    assert (sample_out === exp)
      else begin
        $display("Fail at %0t: sample_out %h, expected %h for segment %0d at time %h",
                 $time, sample_out, exp, seg, t);
        errors++;
      end
  endtask

  // the model takes new settings at the write, and checks resume after the commit.
  task automatic write_reg(input reg_addr_t addr, input int seg, input logic [31:0] data);
    reg_we = 1'b1;
    reg_addr = addr;
    reg_seg = seg[0:0];
    reg_data = data;
    if (addr == reg_cycle) exp_cycle[seg] = data[cycle_w-1:0];
    if (addr == reg_freq_div) exp_fdiv[seg] = data;
    advance();
    reg_we = 1'b0;
  endtask

  task automatic load_table(input int seg);
    logic [63:0] r;
    logic [sample_w-1:0] d;
    for (int a = 0; a < depth; a++) begin
      r = rand_bits(8);
      // the address sits in the high byte, so every entry of a table differs.
      d = {a[7:0], r[7:0]};
      mem_we = 1'b1;
      mem_seg = seg[0:0];
      mem_addr = a[addr_w-1:0];
      mem_data = d;
      tbl_copy[seg][a] = d;
      advance();
    end
    mem_we = 1'b0;
  endtask

  task automatic commit_and_wait(input int old_seg, input int new_seg, input bit chk,
                                 output int lat);
    bit seen;
    seen = 1'b0;
    reg_we = 1'b1;
    reg_addr = reg_commit;
    reg_data = '0;
    advance();
    reg_we = 1'b0;
    lat = 1;
    while (!seen && lat < 2 * done_advance) begin
      if (chk) begin
        check_value("segment", 64'(segment), 64'(old_seg));
        check_sample(old_seg);
      end
      if (update_done) begin
        seen = 1'b1;
      end else begin
        advance();
        lat++;
      end
    end
    if (!seen) begin
      $display("update_done did not arrive within %0d cycles of the commit", lat);
      errors++;
    end
    // segment takes the request one edge after update_done, and the sample one edge later.
    advance();
    check_value("segment", 64'(segment), 64'(new_seg));
    if (chk) check_sample(old_seg);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - err_before);
    end
  endtask

  `include "stm_core_tests.svh"

  initial begin
    reset = 1'b1;
    reg_we = 1'b0;
    reg_addr = reg_cycle;
    reg_seg = '0;
    reg_data = '0;
    mem_we = 1'b0;
    mem_seg = '0;
    mem_addr = '0;
    mem_data = '0;
    sys_time = '0;
    for (int i = 0; i < num_segment; i++) begin
      exp_cycle[i] = '0;
      exp_fdiv[i] = 32'd1;
    end
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    reset = 1'b0;
    reset_state();
    commit_timing();
    index_path();
    segment_switch();
    random_settings();
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- stm_core.f
+incdir+test
hw/stm_pkg.sv
hw/pipe_divider.sv
hw/stm_settings.sv
hw/stm_timer.sv
hw/stm_sample_mem.sv
hw/stm_output.sv
hw/stm_core.sv
test/stm_core_tb.sv

//--- Makefile
# Verilator build and run of the STM core testbench.

VERILATOR ?= verilator
TOP ?= stm_core_tb
RTL_TOP ?= stm_core
FILELIST ?= stm_core.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= TESTBENCH PASSED
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard hw/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
